/* hw/ads_sum_cfg.svh */
`ifndef ADS_SUM_CFG_SVH
`define ADS_SUM_CFG_SVH

// **********************************************************
// Datapath sizes
// **********************************************************
`define ADS_DATA_W       64  // ADC word and AXI data
`define ADS_LANE_W       16  // One channel sample
`define ADS_LANES        8   // Samples in one ad0/ad1 pair
`define ADS_SUM_W        32  // Running sum, wraps

// Block geometry
`define ADS_BLOCK_PAIRS  32  // Pairs per block
`define ADS_FIFO_WORDS   64  // FIFO depth, same as data burst beats

// **********************************************************
// AXI write master
// **********************************************************
`define ADS_AXI_ID_W     4
`define ADS_ADDR_W       32
`define ADS_ADDR_BASE    32'h0000_0000  // Data burst target
`define ADS_SUM_OFFSET   32'h0000_1000  // Sum word sits above the data

`endif

/* hw/ads_sample_pkg.sv */
`include "ads_sum_cfg.svh"

// Capture side types, ADC words in and channel samples out
package ads_sample_pkg;

	typedef logic [`ADS_DATA_W-1:0] adc_word_t;  // Raw ADC port word
	typedef logic [`ADS_LANE_W-1:0] lane_t;      // One channel sample
	typedef logic [`ADS_SUM_W-1:0]  sum_t;       // Block sum

	// Sample strobe toward FIFO and accumulator
	typedef struct packed {
		logic  valid;
		lane_t data;
	} lane_beat_t;

	// Interleaver states
	typedef enum logic [1:0] {
		CAP_RECEIVE,  // Latching ad0/ad1
		CAP_EMIT,     // Stepping out eight samples
		CAP_HOLD      // Block full, waiting for the writer
	} cap_state_e;

endpackage

/* hw/axi_wr_pkg.sv */
`include "ads_sum_cfg.svh"

// AXI4 write channel bundles as seen from the master
package axi_wr_pkg;

	// Write address channel
	typedef struct packed {
		logic                     valid;
		logic [`ADS_AXI_ID_W-1:0] id;
		logic [`ADS_ADDR_W-1:0]   addr;
		logic [7:0]               len;    // Beats minus one
		logic [2:0]               size;   // Bytes per beat, log2
		logic [1:0]               burst;  // 01 is INCR
	} axi_aw_t;

	// Write data channel
	typedef struct packed {
		logic                     valid;
		logic [`ADS_DATA_W-1:0]   data;
		logic [`ADS_DATA_W/8-1:0] strb;
		logic                     last;
	} axi_w_t;

	// Write response channel, slave to master
	typedef struct packed {
		logic                     valid;
		logic [`ADS_AXI_ID_W-1:0] id;
		logic [1:0]               resp;
	} axi_b_t;

	// Writer FSM, data burst first and then the sum beat
	typedef enum logic [2:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP,
		WR_SUM_ADDR,
		WR_SUM_DATA,
		WR_SUM_RESP
	} wr_state_e;

endpackage

/* hw/adc_lane_interleaver.sv */
`timescale 1ns/1ps
`include "ads_sum_cfg.svh"

// ad0 carries ch0/2/4/6 and ad1 carries ch1/3/5/7, top slice first
module adc_lane_interleaver (
	input  logic                       sys_clk,
	input  logic                       sys_rst,
	input  logic                       i_ad0_valid,
	input  ads_sample_pkg::adc_word_t  i_ad0_data,
	input  logic                       i_ad1_valid,
	input  ads_sample_pkg::adc_word_t  i_ad1_data,
	input  logic                       i_fifo_full,
	input  logic                       i_block_ready,
	input  logic                       i_block_clear,
	output ads_sample_pkg::lane_beat_t o_lane,
	output logic                       o_pair_done
);

	ads_sample_pkg::cap_state_e state;
	ads_sample_pkg::adc_word_t  ad0_q;
	ads_sample_pkg::adc_word_t  ad1_q;
	logic                       ad0_held;  // Ports may arrive skewed
	logic                       ad1_held;
	logic [2:0]                 lane_idx;  // Position in ch0..ch7
	ads_sample_pkg::lane_t      lane_sel;
	logic                       emit;

	// **********************************************************
	// Sample select
	// **********************************************************
	// Even index from ad0, odd from ad1, slice steps down every two
	always_comb begin
		if (lane_idx[0])
			lane_sel = ad1_q[`ADS_DATA_W - 1 - lane_idx[2:1] * `ADS_LANE_W -: `ADS_LANE_W];
		else
			lane_sel = ad0_q[`ADS_DATA_W - 1 - lane_idx[2:1] * `ADS_LANE_W -: `ADS_LANE_W];
	end

	// First sample leaves straight from RECEIVE once both words are in
	assign emit = (state == ads_sample_pkg::CAP_EMIT) ||
		(state == ads_sample_pkg::CAP_RECEIVE && ad0_held && ad1_held &&
		!i_fifo_full && !i_block_ready);

	// **********************************************************
	// Capture FSM
	// **********************************************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state       <= ads_sample_pkg::CAP_RECEIVE;
			ad0_held    <= 1'b0;
			ad1_held    <= 1'b0;
			lane_idx    <= 3'd0;
			o_lane      <= '0;
			o_pair_done <= 1'b0;
		end else begin
			o_lane.valid <= emit;
			o_pair_done  <= emit && (lane_idx == 3'd7);  // With ch7
			if (emit) begin
				o_lane.data <= lane_sel;
				lane_idx    <= lane_idx + 3'd1;  // Wraps to 0 after ch7
			end
			case (state)
				ads_sample_pkg::CAP_RECEIVE: begin
					if (i_ad0_valid && !ad0_held) begin
						ad0_q    <= i_ad0_data;
						ad0_held <= 1'b1;
					end
					if (i_ad1_valid && !ad1_held) begin
						ad1_q    <= i_ad1_data;
						ad1_held <= 1'b1;
					end
					if (i_block_ready)
						state <= ads_sample_pkg::CAP_HOLD;  // Latched words kept
					else if (emit)
						state <= ads_sample_pkg::CAP_EMIT;
				end
				ads_sample_pkg::CAP_EMIT: begin
					if (lane_idx == 3'd7) begin
						ad0_held <= 1'b0;  // Free both latches
						ad1_held <= 1'b0;
						state    <= ads_sample_pkg::CAP_RECEIVE;
					end
				end
				ads_sample_pkg::CAP_HOLD: begin
					if (i_block_clear)
						state <= ads_sample_pkg::CAP_RECEIVE;
				end
				default: state <= ads_sample_pkg::CAP_RECEIVE;
			endcase
		end
	end

endmodule

/* hw/lane_pack_fifo.sv */
`timescale 1ns/1ps
`include "ads_sum_cfg.svh"

// Packs four samples per word, oldest sample in the top slice
module lane_pack_fifo (
	input  logic                       sys_clk,
	input  logic                       sys_rst,
	input  ads_sample_pkg::lane_beat_t i_lane,
	input  logic                       i_rd_en,
	output logic                       o_full,
	output ads_sample_pkg::adc_word_t  o_rd_data
);

	localparam int PTR_W  = $clog2(`ADS_FIFO_WORDS);
	localparam int CNT_W  = $clog2(`ADS_FIFO_WORDS + 1);
	localparam int PACK_W = `ADS_DATA_W - `ADS_LANE_W;  // Three samples waiting

	ads_sample_pkg::adc_word_t mem [`ADS_FIFO_WORDS];
	logic [PTR_W-1:0]          wr_ptr;
	logic [PTR_W-1:0]          rd_ptr;
	logic [CNT_W-1:0]          fill;      // Words stored
	logic [1:0]                lane_cnt;  // Slot of the incoming sample
	logic [PACK_W-1:0]         pack_q;
	logic                      word_wr;

	assign word_wr = i_lane.valid && (lane_cnt == 2'd3);  // Fourth sample closes word

	// A pair is two words, so keep two free
	assign o_full = fill >= CNT_W'(`ADS_FIFO_WORDS - 1);

	// **********************************************************
	// Pointers and fill
	// **********************************************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			lane_cnt <= 2'd0;
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fill     <= '0;
		end else begin
			if (i_lane.valid)
				lane_cnt <= lane_cnt + 2'd1;
			if (word_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({word_wr, i_rd_en})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;  // Both or neither
			endcase
		end
	end

	// Packing and storage
	always_ff @(posedge sys_clk) begin
		if (i_lane.valid)
			pack_q <= {pack_q[PACK_W-`ADS_LANE_W-1:0], i_lane.data};
		if (word_wr)
			mem[wr_ptr] <= {pack_q, i_lane.data};
		if (i_rd_en)
			o_rd_data <= mem[rd_ptr];  // Valid the next cycle
	end

endmodule

/* hw/block_accumulator.sv */
`timescale 1ns/1ps
`include "ads_sum_cfg.svh"

// Running sum and pair count for one block
module block_accumulator (
	input  logic                       sys_clk,
	input  logic                       sys_rst,
	input  ads_sample_pkg::lane_beat_t i_lane,
	input  logic                       i_pair_done,
	input  logic                       i_block_clear,
	output ads_sample_pkg::sum_t       o_sum,
	output logic                       o_block_ready
);

	localparam int PAIR_W = $clog2(`ADS_BLOCK_PAIRS + 1);

	logic [PAIR_W-1:0] pair_cnt;

	// **********************************************************
	// Sum and block flag
	// **********************************************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			o_sum         <= '0;
			pair_cnt      <= '0;
			o_block_ready <= 1'b0;
		end else if (i_block_clear) begin
			// Writer done with the block
			o_sum         <= '0;
			pair_cnt      <= '0;
			o_block_ready <= 1'b0;
		end else begin
			if (i_lane.valid)
				o_sum <= o_sum + ads_sample_pkg::sum_t'(i_lane.data);  // Wraps at 32 bits
			if (i_pair_done) begin
				pair_cnt <= pair_cnt + 1'b1;
				// Last pair, flag rises with its final sample summed
				if (pair_cnt == PAIR_W'(`ADS_BLOCK_PAIRS - 1))
					o_block_ready <= 1'b1;
			end
		end
	end

endmodule

/* hw/axi_burst_writer.sv */
`timescale 1ns/1ps
`include "ads_sum_cfg.svh"

// AXI4 write master, 64 beat data burst and then one sum beat
module axi_burst_writer (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	input  logic                      i_block_ready,
	input  ads_sample_pkg::sum_t      i_sum,
	input  ads_sample_pkg::adc_word_t i_fifo_data,
	input  logic                      i_awready,
	input  logic                      i_wready,
	input  axi_wr_pkg::axi_b_t        i_b,
	output logic                      o_fifo_rd,
	output axi_wr_pkg::axi_aw_t       o_aw,
	output axi_wr_pkg::axi_w_t        o_w,
	output logic                      o_bready,
	output logic                      o_block_clear
);

	localparam int         BEAT_W     = $clog2(`ADS_FIFO_WORDS);
	localparam logic [2:0] AXI_SIZE   = 3'($clog2(`ADS_DATA_W / 8));  // Full width beats
	localparam logic [1:0] BURST_INCR = 2'b01;

	axi_wr_pkg::wr_state_e    state;
	logic [BEAT_W-1:0]        beat_cnt;  // Data beats accepted
	logic [`ADS_AXI_ID_W-1:0] id_cnt;
	logic                     start;
	logic                     aw_fire;
	logic                     w_fire;
	logic                     b_fire;

	// Address beat with the running ID
	function automatic axi_wr_pkg::axi_aw_t aw_beat(
		input logic [`ADS_AXI_ID_W-1:0] id,
		input logic [`ADS_ADDR_W-1:0]   addr,
		input logic [7:0]               len
	);
		axi_wr_pkg::axi_aw_t aw;
		aw.valid = 1'b1;
		aw.id    = id;
		aw.addr  = addr;
		aw.len   = len;
		aw.size  = AXI_SIZE;
		aw.burst = BURST_INCR;
		return aw;
	endfunction

	// Block flag stays up one cycle past our clear pulse
	assign start   = (state == axi_wr_pkg::WR_IDLE) && i_block_ready && !o_block_clear;
	assign aw_fire = o_aw.valid && i_awready;
	assign w_fire  = o_w.valid && i_wready;
	assign b_fire  = i_b.valid && o_bready;

	// **********************************************************
	// FIFO prefetch
	// **********************************************************
	// Word 0 on start, word 1 with AW, then one per beat up to word 63
	assign o_fifo_rd = start ||
		(state == axi_wr_pkg::WR_ADDR && aw_fire) ||
		(state == axi_wr_pkg::WR_DATA && w_fire &&
		beat_cnt < BEAT_W'(`ADS_FIFO_WORDS - 2));

	// **********************************************************
	// Write FSM
	// **********************************************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state         <= axi_wr_pkg::WR_IDLE;
			beat_cnt      <= '0;
			id_cnt        <= '0;
			o_aw          <= '0;
			o_w           <= '0;
			o_bready      <= 1'b0;
			o_block_clear <= 1'b0;
		end else begin
			o_block_clear <= 1'b0;
			// One cycle of bready once bvalid shows
			o_bready <= (state == axi_wr_pkg::WR_RESP || state == axi_wr_pkg::WR_SUM_RESP) &&
				i_b.valid && !o_bready;
			case (state)
				axi_wr_pkg::WR_IDLE: begin
					if (start) begin
						o_aw     <= aw_beat(id_cnt, `ADS_ADDR_BASE, 8'(`ADS_FIFO_WORDS - 1));
						id_cnt   <= id_cnt + 1'b1;
						beat_cnt <= '0;
						state    <= axi_wr_pkg::WR_ADDR;
					end
				end
				axi_wr_pkg::WR_ADDR: begin
					if (aw_fire) begin
						o_aw.valid <= 1'b0;
						o_w.valid  <= 1'b1;  // Word 0 already on i_fifo_data
						o_w.data   <= i_fifo_data;
						o_w.strb   <= '1;
						o_w.last   <= 1'b0;
						state      <= axi_wr_pkg::WR_DATA;
					end
				end
				axi_wr_pkg::WR_DATA: begin
					if (w_fire) begin
						beat_cnt <= beat_cnt + 1'b1;
						o_w.data <= i_fifo_data;  // Next word, prefetched
						o_w.last <= beat_cnt == BEAT_W'(`ADS_FIFO_WORDS - 2);
						if (o_w.last) begin
							o_w.valid <= 1'b0;
							state     <= axi_wr_pkg::WR_RESP;
						end
					end
				end
				axi_wr_pkg::WR_RESP: begin
					if (b_fire) begin
						o_aw   <= aw_beat(id_cnt, `ADS_ADDR_BASE + `ADS_SUM_OFFSET, 8'd0);
						id_cnt <= id_cnt + 1'b1;
						state  <= axi_wr_pkg::WR_SUM_ADDR;
					end
				end
				axi_wr_pkg::WR_SUM_ADDR: begin
					if (aw_fire) begin
						o_aw.valid <= 1'b0;
						o_w.valid  <= 1'b1;
						o_w.data   <= {{(`ADS_DATA_W - `ADS_SUM_W){1'b0}}, i_sum};
						o_w.strb   <= '1;
						o_w.last   <= 1'b1;  // Single beat
						state      <= axi_wr_pkg::WR_SUM_DATA;
					end
				end
				axi_wr_pkg::WR_SUM_DATA: begin
					if (w_fire) begin
						o_w.valid <= 1'b0;
						state     <= axi_wr_pkg::WR_SUM_RESP;
					end
				end
				axi_wr_pkg::WR_SUM_RESP: begin
					if (b_fire) begin
						o_block_clear <= 1'b1;  // Reopens capture
						state         <= axi_wr_pkg::WR_IDLE;
					end
				end
				default: state <= axi_wr_pkg::WR_IDLE;
			endcase
		end
	end

endmodule

/* hw/ads_sum_top.sv */
`timescale 1ns/1ps

// Two ADC ports in, AXI4 write master out
module ads_sum_top (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	input  logic                      i_ad0_valid,
	input  ads_sample_pkg::adc_word_t i_ad0_data,
	input  logic                      i_ad1_valid,
	input  ads_sample_pkg::adc_word_t i_ad1_data,
	input  logic                      i_awready,
	input  logic                      i_wready,
	input  axi_wr_pkg::axi_b_t        i_b,
	output axi_wr_pkg::axi_aw_t       o_aw,
	output axi_wr_pkg::axi_w_t        o_w,
	output logic                      o_bready
);

	ads_sample_pkg::lane_beat_t lane;        // Sample strobe
	logic                       pair_done;
	logic                       fifo_full;
	logic                       fifo_rd;
	ads_sample_pkg::adc_word_t  fifo_data;
	ads_sample_pkg::sum_t       sum;
	logic                       block_ready;  // Level until clear
	logic                       block_clear;  // Pulse from writer

	// **********************************************************
	// Capture, pack, sum, write
	// **********************************************************
	adc_lane_interleaver adc_lane_interleaver_i (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.i_ad0_valid(i_ad0_valid), .i_ad0_data(i_ad0_data),
		.i_ad1_valid(i_ad1_valid), .i_ad1_data(i_ad1_data),
		.i_fifo_full(fifo_full), .i_block_ready(block_ready),
		.i_block_clear(block_clear), .o_lane(lane), .o_pair_done(pair_done)
	);

	lane_pack_fifo lane_pack_fifo_i (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .i_lane(lane), .i_rd_en(fifo_rd),
		.o_full(fifo_full), .o_rd_data(fifo_data)
	);

	block_accumulator block_accumulator_i (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .i_lane(lane), .i_pair_done(pair_done),
		.i_block_clear(block_clear), .o_sum(sum), .o_block_ready(block_ready)
	);

	axi_burst_writer axi_burst_writer_i (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .i_block_ready(block_ready),
		.i_sum(sum), .i_fifo_data(fifo_data), .i_awready(i_awready),
		.i_wready(i_wready), .i_b(i_b), .o_fifo_rd(fifo_rd), .o_aw(o_aw),
		.o_w(o_w), .o_bready(o_bready), .o_block_clear(block_clear)
	);

endmodule

/* tb/tb_ads_sum.sv */
`timescale 1ns/1ps
`include "ads_sum_cfg.svh"

module tb_ads_sum;

	localparam int PAIRS   = 2 * `ADS_BLOCK_PAIRS;
	localparam int LIMIT   = 4 * (PAIRS * 12 + 2 * 200);  // Cycles before giving up

	logic                      sys_clk;
	logic                      sys_rst;
	logic                      ad0_valid;
	logic                      ad1_valid;
	ads_sample_pkg::adc_word_t ad0_data;
	ads_sample_pkg::adc_word_t ad1_data;
	logic                      awready;
	logic                      wready;
	axi_wr_pkg::axi_b_t        b_in;
	axi_wr_pkg::axi_aw_t       aw;
	axi_wr_pkg::axi_w_t        w;
	logic                      bready;

	logic [63:0] vec [0:2*PAIRS-1];  // ad0 then ad1 for each pair
	logic [63:0] exp_word [0:1][0:`ADS_FIFO_WORDS-1];
	logic [31:0] exp_sum [0:1];
	logic [31:0] rng_adc;
	logic [31:0] rng_axi;
	int          pairs_sent;
	int          aw_cnt;
	int          w_beat;
	int          blk_w;
	int          b_cnt;
	int          blocks_done;
	int          cycles;
	logic [3:0]  last_id;
	logic        aw_stall;
	logic        w_stall;
	axi_wr_pkg::axi_aw_t aw_prev;
	axi_wr_pkg::axi_w_t  w_prev;

	ads_sum_top ads_sum_top_i (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.i_ad0_valid(ad0_valid), .i_ad0_data(ad0_data),
		.i_ad1_valid(ad1_valid), .i_ad1_data(ad1_data),
		.i_awready(awready), .i_wready(wready), .i_b(b_in),
		.o_aw(aw), .o_w(w), .o_bready(bready)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Sample k of a block in ch0..ch7 order, top slice first
	function automatic logic [15:0] sample_at(input int blk, input int k);
		int          pair;
		int          lane;
		logic [63:0] word;
		pair = blk * `ADS_BLOCK_PAIRS + k / 8;
		lane = k % 8;
		word = (lane % 2 == 1) ? vec[2*pair+1] : vec[2*pair];
		return word[63 - 16 * (lane / 2) -: 16];
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			$display("Test FAILED");
			$fatal(1, "check %s mismatched", name);
		end
	endtask

	// **********************************************************
	// Clock, reset, timeout
	// **********************************************************
	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	initial begin
		sys_rst = 1'b1;
		repeat (10) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;
	end

	initial cycles = 0;
	always @(posedge sys_clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Test FAILED");
			$fatal(1, "run timed out after %0d cycles", cycles);
		end
	end

	// Golden words and sums
	initial begin
		$readmemh("tb/ads_sum_vectors.hex", vec);
		for (int b = 0; b < 2; b++) begin
			exp_sum[b] = 32'd0;
			for (int k = 0; k < 4 * `ADS_FIFO_WORDS; k++)
				exp_sum[b] = exp_sum[b] + 32'(sample_at(b, k));  // Wraps
			for (int j = 0; j < `ADS_FIFO_WORDS; j++)
				exp_word[b][j] = {sample_at(b, 4*j), sample_at(b, 4*j+1),
					sample_at(b, 4*j+2), sample_at(b, 4*j+3)};
		end
	end

	// **********************************************************
	// ADC stimulus
	// **********************************************************
	initial begin
		int d;
		ad0_valid  = 1'b0;
		ad1_valid  = 1'b0;
		ad0_data   = '0;
		ad1_data   = '0;
		pairs_sent = 0;
		rng_adc    = 32'h9c29;
		@(negedge sys_rst);
		repeat (4) @(negedge sys_clk);
		for (int b = 0; b < 2; b++) begin
			for (int p = 0; p < `ADS_BLOCK_PAIRS; p++) begin
				rng_adc = xorshift(rng_adc);
				d = int'(rng_adc % 32'd3);  // ad1 skew
				for (int c = 0; c < 12; c++) begin
					ad0_valid = (c == 0);
					ad1_valid = (c == d);
					if (c == 0)
						ad0_data = vec[2*(b*`ADS_BLOCK_PAIRS+p)];
					if (c == d)
						ad1_data = vec[2*(b*`ADS_BLOCK_PAIRS+p)+1];
					@(negedge sys_clk);
				end
				pairs_sent = pairs_sent + 1;
			end
			while (blocks_done < b + 1)
				@(negedge sys_clk);
			repeat (4) @(negedge sys_clk);  // Clear reaches capture
		end
		check_value("aw count", 64'(4), 64'(aw_cnt));
		check_value("block count", 64'(2), 64'(blk_w));
		$display("Test OK");
		$finish;
	end

	// **********************************************************
	// AXI slave model
	// **********************************************************
	initial begin
		awready = 1'b0;
		wready  = 1'b0;
		rng_axi = 32'h9c29;
		forever begin
			@(negedge sys_clk);
			rng_axi = xorshift(rng_axi);
			awready = rng_axi[0] | rng_axi[1];  // Roughly 3 of 4 ready
			wready  = rng_axi[4] | rng_axi[5];
		end
	end

	// B response two cycles after the last W beat and held until bready
	initial begin
		b_in = '0;
		forever begin
			@(posedge sys_clk);
			if (w.valid && wready && w.last) begin
				repeat (2) @(negedge sys_clk);
				b_in.valid = 1'b1;
				b_in.id    = last_id;
				b_in.resp  = 2'b00;
				@(posedge sys_clk);
				while (!bready)
					@(posedge sys_clk);
				@(negedge sys_clk);
				b_in = '0;
			end
		end
	end

	// **********************************************************
	// Monitor and checks
	// **********************************************************
	initial begin
		aw_cnt      = 0;
		w_beat      = 0;
		blk_w       = 0;
		b_cnt       = 0;
		blocks_done = 0;
		last_id     = 4'd0;
		aw_stall    = 1'b0;
		w_stall     = 1'b0;
	end

	always @(posedge sys_clk) begin
		if (sys_rst || pairs_sent < `ADS_BLOCK_PAIRS) begin
			check_value("reset awvalid", 64'(0), 64'(aw.valid));
			check_value("reset wvalid", 64'(0), 64'(w.valid));
			check_value("reset bready", 64'(0), 64'(bready));
		end else begin
			if (aw_stall)
				check_value("aw held under stall", 64'(aw_prev), 64'(aw));
			if (w_stall) begin
				check_value("w data held under stall", w_prev.data, w.data);
				check_value("w ctrl held under stall",
					64'({w_prev.valid, w_prev.strb, w_prev.last}),
					64'({w.valid, w.strb, w.last}));
			end
			aw_stall = aw.valid && !awready;
			aw_prev  = aw;
			w_stall  = w.valid && !wready;
			w_prev   = w;
			if (aw.valid && awready) begin
				check_value("aw id", 64'(4'(aw_cnt)), 64'(aw.id));
				check_value("aw size", 64'(3), 64'(aw.size));
				check_value("aw burst", 64'(1), 64'(aw.burst));
				if (aw_cnt % 2 == 0) begin
					check_value("data addr", 64'(`ADS_ADDR_BASE), 64'(aw.addr));
					check_value("data len", 64'(63), 64'(aw.len));
				end else begin
					check_value("sum addr", 64'(`ADS_ADDR_BASE + `ADS_SUM_OFFSET),
						64'(aw.addr));
					check_value("sum len", 64'(0), 64'(aw.len));
				end
				last_id = aw.id;
				aw_cnt  = aw_cnt + 1;
			end
			if (w.valid && wready) begin
				check_value("w strb", 64'(8'hff), 64'(w.strb));
				if (aw_cnt % 2 == 1) begin
					// Data burst beat
					check_value("data beat", exp_word[blk_w][w_beat], w.data);
					check_value("data last", 64'(w_beat == 63), 64'(w.last));
					w_beat = w_beat + 1;
				end else begin
					check_value("sum data", {32'd0, exp_sum[blk_w]}, w.data);
					check_value("sum last", 64'(1), 64'(w.last));
					check_value("beats per burst", 64'(64), 64'(w_beat));
					w_beat = 0;
					blk_w  = blk_w + 1;
				end
			end
			if (b_in.valid && bready) begin
				b_cnt = b_cnt + 1;
				if (b_cnt % 2 == 0)
					blocks_done = blocks_done + 1;  // Sum write answered
			end
		end
	end

endmodule

/* ads_sum.f */
+incdir+hw
hw/ads_sample_pkg.sv
hw/axi_wr_pkg.sv
hw/adc_lane_interleaver.sv
hw/lane_pack_fifo.sv
hw/block_accumulator.sv
hw/axi_burst_writer.sv
hw/ads_sum_top.sv
tb/tb_ads_sum.sv

/* Makefile */
SIM = obj_dir/Vtb_ads_sum

.PHONY: sim clean

sim:
	verilator --binary --timing -Ihw -f ads_sum.f --top-module tb_ads_sum -o Vtb_ads_sum
	@out="$$(./$(SIM))"; status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* tb/ads_sum_vectors.hex */
// One ADC pair per line: ad0 word then ad1 word, 64 bits each
// Lines 1 to 32 form block 0, lines 33 to 64 form block 1
a000a200a400a600 b100b300b500b700
a001a201a401a601 b101b301b501b701
a002a202a402a602 b102b302b502b702
a003a203a403a603 b103b303b503b703
a004a204a404a604 b104b304b504b704
a005a205a405a605 b105b305b505b705
a006a206a406a606 b106b306b506b706
a007a207a407a607 b107b307b507b707
a008a208a408a608 b108b308b508b708
a009a209a409a609 b109b309b509b709
a00aa20aa40aa60a b10ab30ab50ab70a
a00ba20ba40ba60b b10bb30bb50bb70b
a00ca20ca40ca60c b10cb30cb50cb70c
a00da20da40da60d b10db30db50db70d
a00ea20ea40ea60e b10eb30eb50eb70e
a00fa20fa40fa60f b10fb30fb50fb70f
a010a210a410a610 b110b310b510b710
a011a211a411a611 b111b311b511b711
a012a212a412a612 b112b312b512b712
a013a213a413a613 b113b313b513b713
a014a214a414a614 b114b314b514b714
a015a215a415a615 b115b315b515b715
a016a216a416a616 b116b316b516b716
a017a217a417a617 b117b317b517b717
a018a218a418a618 b118b318b518b718
a019a219a419a619 b119b319b519b719
a01aa21aa41aa61a b11ab31ab51ab71a
a01ba21ba41ba61b b11bb31bb51bb71b
a01ca21ca41ca61c b11cb31cb51cb71c
a01da21da41da61d b11db31db51db71d
a01ea21ea41ea61e b11eb31eb51eb71e
a01fa21fa41fa61f b11fb31fb51fb71f
c020c220c420c620 d120d320d520d720
c021c221c421c621 d121d321d521d721
c022c222c422c622 d122d322d522d722
c023c223c423c623 d123d323d523d723
c024c224c424c624 d124d324d524d724
c025c225c425c625 d125d325d525d725
c026c226c426c626 d126d326d526d726
c027c227c427c627 d127d327d527d727
c028c228c428c628 d128d328d528d728
c029c229c429c629 d129d329d529d729
c02ac22ac42ac62a d12ad32ad52ad72a
c02bc22bc42bc62b d12bd32bd52bd72b
c02cc22cc42cc62c d12cd32cd52cd72c
c02dc22dc42dc62d d12dd32dd52dd72d
c02ec22ec42ec62e d12ed32ed52ed72e
c02fc22fc42fc62f d12fd32fd52fd72f
c030c230c430c630 d130d330d530d730
c031c231c431c631 d131d331d531d731
c032c232c432c632 d132d332d532d732
c033c233c433c633 d133d333d533d733
c034c234c434c634 d134d334d534d734
c035c235c435c635 d135d335d535d735
c036c236c436c636 d136d336d536d736
c037c237c437c637 d137d337d537d737
c038c238c438c638 d138d338d538d738
c039c239c439c639 d139d339d539d739
c03ac23ac43ac63a d13ad33ad53ad73a
c03bc23bc43bc63b d13bd33bd53bd73b
c03cc23cc43cc63c d13cd33cd53cd73c
c03dc23dc43dc63d d13dd33dd53dd73d
c03ec23ec43ec63e d13ed33ed53ed73e
c03fc23fc43fc63f d13fd33fd53fd73f
